//--- Makefile
TOP := calc_tb

sim:
	verilator --binary --timing --assert --timescale 1ns/100ps -Wno-fatal \
		--top-module $(TOP) -f calc.f -Mdir obj_dir -o calc_sim
	./obj_dir/calc_sim | tee sim.log
	grep -q "SIMULATION PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- bench/calc_tb.sv
`include "calc_cfg.svh"

module calc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int W         = `CALC_WIDTH;
    localparam int BW        = 4 * `CALC_BCD_DIGITS;
    localparam int N_RANDOM  = 200;
    localparam int MAX_KEYS  = 320;                         // directed plus random, rounded up
    localparam int KEY_SLACK = 80;                          // scan, result stage, idle gap
    localparam int UPD_LIMIT = `CALC_DEBOUNCE + 2 * W + 40; // clocks allowed per press

    logic          clk;
    logic          nRST;
    logic [3:0]    row_in;
    logic [3:0]    col_out;
    logic          disp_neg;
    logic [BW-1:0] disp_bcd;
    logic          disp_update;

    logic          key_down;                    // keypad model state
    logic [1:0]    key_row;
    logic [1:0]    key_col;

    logic signed [W-1:0] m_entry;               // reference calculator
    logic signed [W-1:0] m_acc;
    logic signed [W-1:0] m_shown;               // value the display should carry
    int            m_pend;                      // 0 load, 1 add, 2 sub, 3 mul
    int            m_ndigits;
    int            errors;
    int            checks;

    calc_top u_calc_top (
        .clk         (clk),
        .nRST        (nRST),
        .row_in      (row_in),
        .col_out     (col_out),
        .disp_neg    (disp_neg),
        .disp_bcd    (disp_bcd),
        .disp_update (disp_update)
    );

    // pressed key shorts its row to its column while that column is driven low
    assign row_in = (key_down && !col_out[key_col]) ? ~(4'b0001 << key_row) : 4'b1111;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;                 // 20 ns period
    end

    initial begin                               // budget per key, never hangs
        repeat (100 + MAX_KEYS * (`CALC_DEBOUNCE + W + KEY_SLACK)) @(posedge clk);
        $display("watchdog expired, the key sequences did not finish in time");
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // key map and left-to-right evaluation
    task automatic apply_model(input int code);
        int                  digit;
        logic signed [W-1:0] res;
        case (code)
            0, 1, 2:  digit = code + 1;
            4, 5, 6:  digit = code;
            8, 9, 10: digit = code - 1;
            13:       digit = 0;
            default:  digit = -1;               // not a digit key
        endcase
        if (digit >= 0) begin
            if (m_ndigits < `CALC_MAX_DIGITS) begin
                m_entry = W'(m_entry * 10 + digit);
                m_ndigits++;
            end
            m_shown = m_entry;                  // extra digits leave entry alone
        end else if (code == 15) begin
            m_entry = -m_entry;
            m_shown = m_entry;
        end else if (code == 14) begin
            m_entry   = '0;
            m_acc     = '0;
            m_pend    = 0;
            m_ndigits = 0;
            m_shown   = '0;
        end else begin                          // add, sub, mul or equals
            case (m_pend)
                1:       res = m_acc + m_entry;
                2:       res = m_acc - m_entry;
                3:       res = m_acc * m_entry; // low 16 bits only
                default: res = m_entry;
            endcase
            m_acc     = res;
            m_pend    = (code == 3) ? 1 : (code == 7) ? 2 : (code == 11) ? 3 : 0;
            m_entry   = '0;
            m_ndigits = 0;
            m_shown   = m_acc;
        end
    endtask

    function automatic logic [BW-1:0] bcd_of(input logic signed [W-1:0] v);
        logic [BW-1:0] b;
        int            mag;
        mag = (v < 0) ? -int'(v) : int'(v);     // -32768 gives 32768
        for (int d = 0; d < `CALC_BCD_DIGITS; d++) begin
            b[4*d +: 4] = 4'(mag % 10);
            mag = mag / 10;
        end
        return b;
    endfunction

    function automatic int key_of_char(input byte ch);
        case (ch)
            "1", "2", "3": return int'(ch - "1");
            "4", "5", "6": return int'(ch - "4") + 4;
            "7", "8", "9": return int'(ch - "7") + 8;
            "0":           return 13;
            "+":           return 3;
            "-":           return 7;
            "*":           return 11;
            "=":           return 12;
            "C":           return 14;
            "N":           return 15;            // negate
            default:       return -1;
        endcase
    endfunction

    // hold key until the display updates, then release and idle
    task automatic press_key(input int code);
        int   waited;
        logic seen;
        @(posedge clk);
        #2;
        key_row  = 2'(code / 4);
        key_col  = 2'(code % 4);
        key_down = 1'b1;
        apply_model(code);
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < UPD_LIMIT) begin
            @(negedge clk);                     // outputs settled mid-cycle
            seen = disp_update;
            waited++;
        end
        if (seen) begin
            compare_value("disp_neg", 32'(disp_neg), 32'(m_shown < 0));
            compare_value("disp_bcd", 32'(disp_bcd), 32'(bcd_of(m_shown)));
            @(negedge clk);
            compare_value("disp_update", 32'(disp_update), 32'h0);  // one-cycle pulse
        end else begin
            errors++;
            $display("no display update within %0d clocks after key %0d", UPD_LIMIT, code);
        end
        @(posedge clk);
        #2;
        key_down = 1'b0;
        repeat (20) @(posedge clk);
    endtask

    task automatic run_keys(input string s);
        int code;
        for (int i = 0; i < s.len(); i++) begin
            code = key_of_char(s[i]);
            if (code < 0) begin
                errors++;
                $display("unknown key character in sequence %s", s);
            end else begin
                press_key(code);
            end
        end
    endtask

    initial begin
        void'($urandom(32'hd3c6));              // seeds the random keys
        errors    = 0;
        checks    = 0;
        nRST      = 1'b0;
        key_down  = 1'b0;
        key_row   = 2'd0;
        key_col   = 2'd0;
        m_entry   = '0;
        m_acc     = '0;
        m_shown   = '0;
        m_pend    = 0;
        m_ndigits = 0;

        repeat (15) @(posedge clk);
        @(negedge clk);
        compare_value("col_out", 32'(col_out), 32'he);   // column 0 low in reset
        compare_value("disp_bcd", 32'(disp_bcd), 32'h0);
        @(posedge clk);                         // sixteenth reset clock
        #2;
        nRST = 1'b1;

        repeat (50) begin                       // idle keypad, display quiet
            @(negedge clk);
            compare_value("disp_update", 32'(disp_update), 32'h0);
            compare_value("disp_bcd", 32'(disp_bcd), 32'h0);
        end

        run_keys("12345");                      // fifth digit dropped
        run_keys("C12+7=");
        run_keys("5-9=");                       // negative result
        run_keys("C9999+9999+9999+9999=");      // sum wraps
        run_keys("C300*200=");                  // product wraps
        run_keys("C7*6N=");
        run_keys("C1234*5678*9=");
        run_keys("C12N+5=");
        run_keys("C45*3C8+2=");                 // clear mid expression
        run_keys("C3-4N=");

        for (int i = 0; i < N_RANDOM; i++)
            press_key(int'($urandom_range(15, 0)));

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

//--- calc.f
+incdir+source
source/calc_pkg.sv
source/keypad_scan.sv
source/key_decode.sv
source/calc_execute.sv
source/calc_result.sv
source/calc_top.sv
bench/calc_tb.sv

//--- source/calc_cfg.svh
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// datapath width of entry, accumulator and shown value
`define CALC_WIDTH 16

// consecutive aligned row samples needed to confirm a press
`define CALC_DEBOUNCE 10

// further digit keys are dropped once an entry has this many
`define CALC_MAX_DIGITS 4

// five digits reach 32768, the largest magnitude
`define CALC_BCD_DIGITS 5

`endif

//--- source/calc_execute.sv
`include "calc_cfg.svh"

module calc_execute
    import calc_pkg::*;
(
    input  logic                          clk,
    input  logic                          nRST,
    input  logic                          tok_req,
    output logic                          tok_ack,
    input  tok_kind_t                     tok_kind,
    input  tok_payload_u                  tok_payload,
    output logic                          disp_req,
    input  logic                          disp_ack,
    output logic signed [`CALC_WIDTH-1:0] disp_value
);

    localparam int W    = `CALC_WIDTH;
    localparam int DC_W = $clog2(`CALC_MAX_DIGITS + 1);
    localparam int MC_W = $clog2(W);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] MUL  = 2'd1;     // shift-add running
    localparam logic [1:0] SHOW = 2'd2;     // waiting on result stage
    localparam logic [1:0] DONE = 2'd3;     // tok_ack high

    logic [1:0]          state;
    logic signed [W-1:0] entry;
    logic signed [W-1:0] acc;
    op_t                 pending;
    logic [DC_W-1:0]     ndigits;
    logic [MC_W-1:0]     mcnt;
    logic [W-1:0]        mcand;             // acc, shifted left each step
    logic [W-1:0]        mplier;            // entry, shifted right each step
    logic [W-1:0]        prod;
    logic [W-1:0]        prod_next;
    logic signed [W-1:0] simple_res;        // add, sub or load
    logic signed [W-1:0] digit_entry;
    logic                room;
    logic                take;
    logic                mul_start;
    logic                mul_last;
    op_t                 next_op;

    assign take      = tok_req && !tok_ack && (state == IDLE);
    assign room      = (ndigits < DC_W'(`CALC_MAX_DIGITS));
    assign mul_start = take && (tok_kind == TK_OP || tok_kind == TK_EQUAL) &&
                       (pending == OP_MUL);
    assign mul_last  = (state == MUL) && (mcnt == MC_W'(W - 1));
    assign prod_next = mplier[0] ? prod + mcand : prod;
    assign next_op   = (tok_kind == TK_OP) ? tok_payload.op.code : OP_LOAD;

    assign digit_entry = room ? entry * W'(10) + W'(tok_payload.digit) : entry;

    always_comb begin
        case (pending)
            OP_ADD:  simple_res = acc + entry;
            OP_SUB:  simple_res = acc - entry;
            default: simple_res = entry;    // load, mul takes the iterative path
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            entry    <= '0;
            acc      <= '0;
            pending  <= OP_LOAD;
            ndigits  <= '0;
            mcnt     <= '0;
            tok_ack  <= 1'b0;
            disp_req <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (take) begin
                        case (tok_kind)
                            TK_DIGIT: begin
                                entry <= digit_entry;
                                if (room)
                                    ndigits <= ndigits + 1'b1;
                            end
                            TK_NEG:   entry <= -entry;
                            TK_CLEAR: begin
                                entry   <= '0;
                                acc     <= '0;
                                pending <= OP_LOAD;
                                ndigits <= '0;
                            end
                            default: begin          // operator or equals
                                if (pending != OP_MUL)
                                    acc <= simple_res;
                                pending <= next_op;
                                entry   <= '0;
                                ndigits <= '0;
                            end
                        endcase
                        mcnt <= '0;
                        if (mul_start) begin
                            state <= MUL;
                        end else begin
                            disp_req <= 1'b1;
                            state    <= SHOW;
                        end
                    end
                end
                MUL: begin
                    mcnt <= mcnt + 1'b1;
                    if (mul_last) begin
                        acc      <= prod_next;  // wrapped product
                        disp_req <= 1'b1;
                        state    <= SHOW;
                    end
                end
                SHOW: begin
                    if (disp_ack) begin
                        disp_req <= 1'b0;
                        tok_ack  <= 1'b1;
                        state    <= DONE;
                    end
                end
                default: begin
                    if (!tok_req && !disp_ack) begin
                        tok_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mul_start) begin
            mcand  <= acc;
            mplier <= entry;
            prod   <= '0;
        end else if (state == MUL) begin
            mcand  <= mcand << 1;
            mplier <= mplier >> 1;
            prod   <= prod_next;
        end
        if (take) begin
            case (tok_kind)
                TK_DIGIT: disp_value <= digit_entry;
                TK_NEG:   disp_value <= -entry;
                TK_CLEAR: disp_value <= '0;
                default:  disp_value <= simple_res;  // replaced after a multiply
            endcase
        end else if (mul_last) begin
            disp_value <= prod_next;
        end
    end

endmodule

//--- source/calc_pkg.sv
package calc_pkg;

    typedef enum logic [2:0] {
        TK_DIGIT,                   // payload is a digit
        TK_OP,                      // payload is an operator
        TK_EQUAL,
        TK_NEG,                     // flip sign of entry
        TK_CLEAR
    } tok_kind_t;

    typedef enum logic [1:0] {
        OP_LOAD,                    // nothing pending, entry goes to acc
        OP_ADD,
        OP_SUB,
        OP_MUL
    } op_t;

    // one nibble, read as a digit or as an operator by token kind
    typedef union packed {
        logic [3:0] digit;          // 0..9
        struct packed {
            logic [1:0] pad;        // always zero
            op_t        code;
        } op;
    } tok_payload_u;

endpackage

//--- source/calc_result.sv
`include "calc_cfg.svh"

module calc_result (
    input  logic                            clk,
    input  logic                            nRST,
    input  logic                            disp_req,
    output logic                            disp_ack,
    input  logic signed [`CALC_WIDTH-1:0]   disp_value,
    output logic                            disp_neg,
    output logic [4*`CALC_BCD_DIGITS-1:0]   disp_bcd,     // digit 0 in low nibble
    output logic                            disp_update
);

    localparam int W    = `CALC_WIDTH;
    localparam int BW   = 4 * `CALC_BCD_DIGITS;
    localparam int SC_W = $clog2(W);

    localparam logic [1:0] IDLE = 2'd0;
    localparam logic [1:0] CONV = 2'd1;     // one bit per clock
    localparam logic [1:0] OUT  = 2'd2;
    localparam logic [1:0] HOLD = 2'd3;     // ack high until req drops

    logic [1:0]      state;
    logic [SC_W-1:0] scnt;
    logic [W-1:0]    mag;                   // unsigned, -32768 fits
    logic            neg_q;
    logic [BW-1:0]   bcd_sh;
    logic [BW-1:0]   bcd_adj;

    function automatic logic bcd_valid(input logic [BW-1:0] b);
        logic ok;
        ok = 1'b1;
        for (int d = 0; d < `CALC_BCD_DIGITS; d++) begin
            if (b[4*d +: 4] > 4'd9)
                ok = 1'b0;
        end
        return ok;
    endfunction

    always_comb begin                       // add 3 to digits of 5 and up
        bcd_adj = bcd_sh;
        for (int d = 0; d < `CALC_BCD_DIGITS; d++) begin
            if (bcd_sh[4*d +: 4] > 4'd4)
                bcd_adj[4*d +: 4] = bcd_sh[4*d +: 4] + 4'd3;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state       <= IDLE;
            scnt        <= '0;
            disp_ack    <= 1'b0;
            disp_update <= 1'b0;
            disp_neg    <= 1'b0;
            disp_bcd    <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (disp_req && !disp_ack) begin
                        scnt  <= '0;
                        state <= CONV;
                    end
                end
                CONV: begin
                    scnt <= scnt + 1'b1;
                    if (scnt == SC_W'(W - 1))
                        state <= OUT;
                end
                OUT: begin
                    disp_neg    <= neg_q;
                    disp_bcd    <= bcd_sh;
                    disp_update <= 1'b1;    // pulses even if unchanged
                    disp_ack    <= 1'b1;
                    state       <= HOLD;
                end
                default: begin
                    disp_update <= 1'b0;
                    if (!disp_req) begin
                        disp_ack <= 1'b0;
                        state    <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && disp_req && !disp_ack) begin
            neg_q  <= disp_value[W-1];
            mag    <= disp_value[W-1] ? W'(-disp_value) : W'(disp_value);
            bcd_sh <= '0;
        end else if (state == CONV) begin
            bcd_sh <= {bcd_adj[BW-2:0], mag[W-1]};   // msb first
            mag    <= mag << 1;
        end
    end

    // digits legal on every display update
    assert property (@(posedge clk) disable iff (!nRST)
        disp_update |-> bcd_valid(disp_bcd))
        else $error("bad BCD digit on display update");

endmodule

//--- source/calc_top.sv
`include "calc_cfg.svh"

module calc_top
    import calc_pkg::*;
(
    input  logic                          clk,
    input  logic                          nRST,
    input  logic [3:0]                    row_in,
    output logic [3:0]                    col_out,
    output logic                          disp_neg,
    output logic [4*`CALC_BCD_DIGITS-1:0] disp_bcd,
    output logic                          disp_update
);

    logic                          key_req;
    logic                          key_ack;
    logic [3:0]                    key_code;
    logic                          tok_req;
    logic                          tok_ack;
    tok_kind_t                     tok_kind;
    tok_payload_u                  tok_payload;
    logic                          disp_req;
    logic                          disp_ack;
    logic signed [`CALC_WIDTH-1:0] disp_value;

    keypad_scan u_keypad_scan (
        .clk      (clk),
        .nRST     (nRST),
        .row_in   (row_in),
        .col_out  (col_out),
        .key_req  (key_req),
        .key_ack  (key_ack),
        .key_code (key_code)
    );

    key_decode u_key_decode (
        .clk         (clk),
        .nRST        (nRST),
        .key_req     (key_req),
        .key_ack     (key_ack),
        .key_code    (key_code),
        .tok_req     (tok_req),
        .tok_ack     (tok_ack),
        .tok_kind    (tok_kind),
        .tok_payload (tok_payload)
    );

    calc_execute u_calc_execute (
        .clk         (clk),
        .nRST        (nRST),
        .tok_req     (tok_req),
        .tok_ack     (tok_ack),
        .tok_kind    (tok_kind),
        .tok_payload (tok_payload),
        .disp_req    (disp_req),
        .disp_ack    (disp_ack),
        .disp_value  (disp_value)
    );

    calc_result u_calc_result (
        .clk         (clk),
        .nRST        (nRST),
        .disp_req    (disp_req),
        .disp_ack    (disp_ack),
        .disp_value  (disp_value),
        .disp_neg    (disp_neg),
        .disp_bcd    (disp_bcd),
        .disp_update (disp_update)
    );

endmodule

//--- source/key_decode.sv
module key_decode
    import calc_pkg::*;
(
    input  logic         clk,
    input  logic         nRST,
    input  logic         key_req,
    output logic         key_ack,
    input  logic [3:0]   key_code,
    output logic         tok_req,
    input  logic         tok_ack,
    output tok_kind_t    tok_kind,
    output tok_payload_u tok_payload
);

    tok_kind_t    map_kind;
    tok_payload_u map_payload;
    logic         start;                // new key, both links idle

    assign start = key_req && !key_ack && !tok_req && !tok_ack;

    always_comb begin
        map_kind    = TK_DIGIT;
        map_payload = '0;
        case (key_code)
            4'd0, 4'd1, 4'd2:  map_payload.digit = key_code + 4'd1;
            4'd4, 4'd5, 4'd6:  map_payload.digit = key_code;
            4'd8, 4'd9, 4'd10: map_payload.digit = key_code - 4'd1;
            4'd13:             map_payload.digit = 4'd0;
            4'd3: begin
                map_kind = TK_OP;
                map_payload.op.code = OP_ADD;
            end
            4'd7: begin
                map_kind = TK_OP;
                map_payload.op.code = OP_SUB;
            end
            4'd11: begin
                map_kind = TK_OP;
                map_payload.op.code = OP_MUL;
            end
            4'd12:   map_kind = TK_EQUAL;
            4'd14:   map_kind = TK_CLEAR;
            default: map_kind = TK_NEG;     // key 15
        endcase
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            tok_req <= 1'b0;
            key_ack <= 1'b0;
        end else if (start) begin
            tok_req <= 1'b1;
        end else if (tok_req && tok_ack) begin
            tok_req <= 1'b0;                // scan ack follows execute ack
            key_ack <= 1'b1;
        end else if (key_ack && !key_req) begin
            key_ack <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tok_kind    <= map_kind;
            tok_payload <= map_payload;
        end
    end

    // execute must have closed the previous token
    assert property (@(posedge clk) disable iff (!nRST)
        $rose(tok_req) |-> !tok_ack)
        else $error("tok_req rose while tok_ack still high");

endmodule

//--- source/keypad_scan.sv
`include "calc_cfg.svh"

module keypad_scan (
    input  logic       clk,
    input  logic       nRST,
    input  logic [3:0] row_in,          // pulled up, low on a pressed key
    output logic [3:0] col_out,         // one column driven low
    output logic       key_req,
    input  logic       key_ack,
    output logic [3:0] key_code         // row * 4 + column
);

    localparam int DB_W = $clog2(`CALC_DEBOUNCE + 1);

    localparam logic [1:0] SCAN     = 2'd0;
    localparam logic [1:0] DEBOUNCE = 2'd1;
    localparam logic [1:0] REQUEST  = 2'd2;
    localparam logic [1:0] RELEASE  = 2'd3;

    logic [1:0]      state;
    logic [1:0]      col;               // column currently driven
    logic [1:0]      col_d1;            // column history, tracks the synchronizer
    logic [1:0]      col_d2;
    logic [3:0]      row_meta;
    logic [3:0]      row_sync;
    logic [DB_W-1:0] db_cnt;
    logic            pressed;           // any synced row low
    logic            aligned;           // synced rows belong to the driven column
    logic            confirm;           // last debounce sample seen
    logic [1:0]      row_idx;

    always_comb begin
        col_out = 4'b1111;
        col_out[col] = 1'b0;
    end

    assign pressed = ~&row_sync;
    assign aligned = (col_d2 == col);
    assign confirm = (state == DEBOUNCE) && aligned && pressed &&
                     (db_cnt == DB_W'(`CALC_DEBOUNCE - 1));

    always_comb begin                   // lowest low row wins
        row_idx = 2'd0;
        for (int r = 3; r >= 0; r--) begin
            if (!row_sync[r])
                row_idx = 2'(r);
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            row_meta <= 4'hF;           // released
            row_sync <= 4'hF;
            col_d1   <= 2'd0;
            col_d2   <= 2'd0;
        end else begin
            row_meta <= row_in;
            row_sync <= row_meta;
            col_d1   <= col;            // same two stages as the rows
            col_d2   <= col_d1;
        end
    end

    always_ff @(posedge clk or negedge nRST) begin
        if (!nRST) begin
            state   <= SCAN;
            col     <= 2'd0;
            db_cnt  <= '0;
            key_req <= 1'b0;
        end else begin
            case (state)
                SCAN: begin
                    if (pressed) begin
                        col    <= col_d2;   // lock on the column that gave the low row
                        db_cnt <= '0;
                        state  <= DEBOUNCE;
                    end else begin
                        col <= col + 2'd1;
                    end
                end
                DEBOUNCE: begin
                    if (!aligned) begin
                        db_cnt <= '0;       // pipeline still holds older columns
                    end else if (!pressed) begin
                        state <= SCAN;      // bounce, start over
                    end else if (confirm) begin
                        key_req <= 1'b1;
                        state   <= REQUEST;
                    end else begin
                        db_cnt <= db_cnt + 1'b1;
                    end
                end
                REQUEST: begin
                    if (key_ack) begin
                        key_req <= 1'b0;
                        state   <= RELEASE;
                    end
                end
                default: begin              // RELEASE
                    if (!pressed && !key_ack)
                        state <= SCAN;      // all rows high again
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (confirm)
            key_code <= {row_idx, col};
    end

    // code and request hold until decode acknowledges
    assert property (@(posedge clk) disable iff (!nRST)
        key_req && !key_ack |=> key_req && $stable(key_code))
        else $error("key_code or key_req moved before key_ack");

endmodule
